// ==== lbist_pkg.sv ====
// ===================================================================
// Shared widths, types, constant tables and reference models for the
// LBIST subsystem. Every LBIST module imports this package.
// ===================================================================

package lbist_pkg;

  localparam int SIGNATURE_BITS      = 32;
  localparam int NUM_HASHES          = 8;
  localparam int MAX_OUTPUTS_TO_HASH = 32;
  localparam int COUNT_BITS          = $clog2(MAX_OUTPUTS_TO_HASH) + 1;  // Must hold 32 itself

  typedef logic [SIGNATURE_BITS-1:0]     sig_t;       // Seed, pattern, response, signature
  typedef logic [NUM_HASHES-1:0]         result_t;    // One pass bit per hash run
  typedef logic [COUNT_BITS-1:0]         count_t;
  typedef logic [$clog2(NUM_HASHES)-1:0] hash_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    COMP_SIG
  } ctrl_state_t;

  localparam sig_t LFSR_TAPS = 32'h80200003;  // Galois feedback mask
  localparam sig_t MISR_TAPS = 32'h04C11DB7;

  localparam sig_t LFSR_SEEDS [NUM_HASHES] = '{
    32'h0a89687e, 32'ha87ded5f, 32'h481c5077, 32'h81595729,
    32'hffd39769, 32'h24b05d57, 32'h9913b1fd, 32'hd8df8ed2
  };

  // ==================================================================
  // Step rules shared by the RTL and the golden model
  // ==================================================================

  // All-zero seed would lock the LFSR
  function automatic sig_t lfsr_load(sig_t seed);
    return (seed == '0) ? '1 : seed;
  endfunction

  function automatic sig_t lfsr_next(sig_t p);
    return (p >> 1) ^ (p[0] ? LFSR_TAPS : '0);
  endfunction

  // CUT mixing: (p ^ rotl7) + rotl13, wraps mod 2^32
  function automatic sig_t cut_mix(sig_t p);
    sig_t rot7;
    sig_t rot13;
    rot7  = (p << 7) | (p >> (SIGNATURE_BITS - 7));
    rot13 = (p << 13) | (p >> (SIGNATURE_BITS - 13));
    return (p ^ rot7) + rot13;
  endfunction

  function automatic sig_t misr_next(sig_t sig, sig_t data);
    return ((sig << 1) ^ (sig[SIGNATURE_BITS-1] ? MISR_TAPS : '0)) ^ data;
  endfunction

  // Cycle model of one fault-free run. The first response is seen
  // twice since the CUT output register fills before the first step
  function automatic sig_t golden_signature(sig_t seed);
    sig_t pat;
    sig_t resp;
    sig_t sig;
    pat  = lfsr_load(seed);
    resp = cut_mix(pat);
    sig  = '0;
    for (int k = 0; k < MAX_OUTPUTS_TO_HASH; k++) begin
      sig  = misr_next(sig, resp);
      resp = cut_mix(pat);
      pat  = lfsr_next(pat);
    end
    return sig;
  endfunction

  localparam sig_t EXPECTED_SIGNATURES [NUM_HASHES] = '{
    golden_signature(LFSR_SEEDS[0]), golden_signature(LFSR_SEEDS[1]),
    golden_signature(LFSR_SEEDS[2]), golden_signature(LFSR_SEEDS[3]),
    golden_signature(LFSR_SEEDS[4]), golden_signature(LFSR_SEEDS[5]),
    golden_signature(LFSR_SEEDS[6]), golden_signature(LFSR_SEEDS[7])
  };

endpackage

// ==== lbist_lfsr.sv ====
// ===================================================================
// Galois LFSR pattern source. Loaded with a seed over valid/ready,
// then advanced one step per cycle while the MISR asks for it.
// ===================================================================

module lbist_lfsr import lbist_pkg::*; (
  input  logic clk,
  input  logic reset,

  input  logic seed_val,
  input  sig_t seed,
  output logic seed_rdy,

  input  logic step,
  output sig_t pattern
);

  logic seed_rdy_q;
  logic load;
  sig_t pattern_q;

  assign load     = seed_val && seed_rdy_q;
  assign seed_rdy = seed_rdy_q;
  assign pattern  = pattern_q;

  // Busy for one cycle after a load
  always_ff @(posedge clk) begin
    if (reset) begin
      seed_rdy_q <= 1'b1;
    end else begin
      seed_rdy_q <= !load;
    end
  end

  // ==================================================================
  // Pattern register
  // ==================================================================

  always_ff @(posedge clk) begin
    if (load) begin
      pattern_q <= lfsr_load(seed);      // Zero seed mapped to all ones
    end else if (step) begin
      pattern_q <= lfsr_next(pattern_q);
    end
  end

endmodule

// ==== lbist_cut.sv ====
// ===================================================================
// Circuit under test: a fixed 32-bit mixing stage with an output
// register. Set bits in fault_mask model stuck-at-zero outputs.
// ===================================================================

module lbist_cut import lbist_pkg::*; (
  input  logic clk,
  input  logic reset,

  input  sig_t pattern,
  input  sig_t fault_mask,
  output sig_t response
);

  sig_t mixed;
  sig_t faulted;

  // Combinational cloud
  assign mixed   = cut_mix(pattern);
  assign faulted = mixed & ~fault_mask;   // Stuck-at-zero injection

  // One cycle from pattern to response
  always_ff @(posedge clk) begin
    if (reset) begin
      response <= '0;
    end else begin
      response <= faulted;
    end
  end

endmodule

// ==== lbist_misr.sv ====
// ===================================================================
// Multiple-input signature register. A request gives the number of
// CUT responses to compact; the signature comes back on valid/ready.
// ===================================================================

module lbist_misr import lbist_pkg::*; (
  input  logic   clk,
  input  logic   reset,

  input  logic   req_val,
  input  count_t req_count,
  output logic   req_rdy,

  input  sig_t   data,          // CUT response
  output logic   lfsr_step,

  output logic   resp_val,
  output sig_t   resp_sig,
  input  logic   resp_rdy
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_SETTLE,     // First pattern still on its way through the CUT
    M_CAPTURE,
    M_RESPOND
  } misr_state_t;

  misr_state_t state_q;
  count_t      count_q;
  sig_t        sig_q;

  assign req_rdy   = (state_q == M_IDLE);
  assign lfsr_step = (state_q == M_CAPTURE);
  assign resp_val  = (state_q == M_RESPOND);
  assign resp_sig  = sig_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= M_IDLE;
    end else begin
      case (state_q)
        M_IDLE:    if (req_val) state_q <= M_SETTLE;
        M_SETTLE:  state_q <= (count_q == '0) ? M_RESPOND : M_CAPTURE;
        M_CAPTURE: if (count_q == count_t'(1)) state_q <= M_RESPOND;  // Last response
        M_RESPOND: if (resp_rdy) state_q <= M_IDLE;
        default:   state_q <= M_IDLE;
      endcase
    end
  end

  // ==================================================================
  // Signature and down counter
  // ==================================================================

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      sig_q   <= '0;
      count_q <= req_count;
    end else if (lfsr_step) begin
      sig_q   <= misr_next(sig_q, data);
      count_q <= count_q - count_t'(1);
    end
  end

endmodule

// ==== lbist_controller.sv ====
// ===================================================================
// LBIST sequencer. Runs NUM_HASHES seed/compact/compare passes and
// returns a pass map with one bit per run to the requestor.
// ===================================================================

module lbist_controller import lbist_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  // Requestor side
  input  logic    lbist_req_val,
  output logic    lbist_req_rdy,
  output logic    lbist_resp_val,
  output result_t lbist_resp_msg,     // Bit i set when run i matched
  input  logic    lbist_resp_rdy,

  // Seed to LFSR
  output logic    lfsr_seed_val,
  output sig_t    lfsr_seed,
  input  logic    lfsr_seed_rdy,

  // MISR request and response
  output logic    misr_req_val,
  output count_t  misr_req_count,
  input  logic    misr_req_rdy,
  input  logic    misr_resp_val,
  input  sig_t    misr_resp_sig,
  output logic    misr_resp_rdy
);

  ctrl_state_t state_q;
  ctrl_state_t next_state;
  hash_idx_t   idx_q;
  result_t     pass_q;
  logic        resp_val_q;
  logic        seed_done_q;   // Seed taken by the LFSR this run
  logic        count_done_q;  // Count taken by the MISR this run
  sig_t        sig_q;
  logic        last_run;
  logic        misr_done;

  assign last_run  = (idx_q == hash_idx_t'(NUM_HASHES - 1));
  assign misr_done = misr_resp_val && misr_resp_rdy;

  // ==================================================================
  // Channel outputs
  // ==================================================================

  assign lbist_req_rdy  = (state_q == IDLE);
  assign lbist_resp_val = resp_val_q;
  assign lbist_resp_msg = pass_q;

  assign lfsr_seed_val  = (state_q == START) && !seed_done_q;
  assign lfsr_seed      = LFSR_SEEDS[idx_q];

  assign misr_req_val   = (state_q == START) && !count_done_q;
  assign misr_req_count = count_t'(MAX_OUTPUTS_TO_HASH);
  assign misr_resp_rdy  = (state_q == START);

  // ==================================================================
  // Next state
  // ==================================================================

  always_comb begin
    next_state = state_q;
    case (state_q)
      IDLE: begin
        if (lbist_req_val) next_state = START;
      end
      START: begin
        if (misr_done) next_state = COMP_SIG;
      end
      COMP_SIG: begin
        if (!resp_val_q) begin
          if (!last_run) next_state = START;   // More runs to go
        end else if (lbist_resp_rdy) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= IDLE;
      idx_q        <= '0;
      pass_q       <= '0;
      resp_val_q   <= 1'b0;
      seed_done_q  <= 1'b0;
      count_done_q <= 1'b0;
    end else begin
      state_q <= next_state;
      case (state_q)
        IDLE: begin
          if (lbist_req_val) begin
            idx_q  <= '0;
            pass_q <= '0;      // Fresh map for each request
          end
        end
        START: begin
          if (lfsr_seed_val && lfsr_seed_rdy) seed_done_q <= 1'b1;
          if (misr_req_val && misr_req_rdy) count_done_q <= 1'b1;
          if (misr_done) begin
            seed_done_q  <= 1'b0;
            count_done_q <= 1'b0;
          end
        end
        COMP_SIG: begin
          if (!resp_val_q) begin
            pass_q[idx_q] <= (sig_q == EXPECTED_SIGNATURES[idx_q]);
            if (last_run) begin
              resp_val_q <= 1'b1;
            end else begin
              idx_q <= idx_q + hash_idx_t'(1);
            end
          end else if (lbist_resp_rdy) begin
            resp_val_q <= 1'b0;
          end
        end
        default: begin
          resp_val_q <= 1'b0;
        end
      endcase
    end
  end

  // Signature captured at the MISR handshake
  always_ff @(posedge clk) begin
    if (misr_done) sig_q <= misr_resp_sig;
  end

endmodule

// ==== lbist_top.sv ====
// ===================================================================
// LBIST subsystem top. Controller sequences the LFSR -> CUT -> MISR
// chain; fault_mask forces stuck-at-zero faults into the CUT.
// ===================================================================

module lbist_top import lbist_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  input  logic    lbist_req_val,
  output logic    lbist_req_rdy,
  output logic    lbist_resp_val,
  output result_t lbist_resp_msg,
  input  logic    lbist_resp_rdy,

  input  sig_t    fault_mask      // Change only while lbist_req_rdy is high
);

  logic   lfsr_seed_val;
  sig_t   lfsr_seed;
  logic   lfsr_seed_rdy;
  logic   misr_req_val;
  count_t misr_req_count;
  logic   misr_req_rdy;
  logic   misr_resp_val;
  sig_t   misr_resp_sig;
  logic   misr_resp_rdy;
  logic   lfsr_step;
  sig_t   pattern;
  sig_t   cut_response;

  lbist_controller u_controller (
    .clk            (clk),
    .reset          (reset),
    .lbist_req_val  (lbist_req_val),
    .lbist_req_rdy  (lbist_req_rdy),
    .lbist_resp_val (lbist_resp_val),
    .lbist_resp_msg (lbist_resp_msg),
    .lbist_resp_rdy (lbist_resp_rdy),
    .lfsr_seed_val  (lfsr_seed_val),
    .lfsr_seed      (lfsr_seed),
    .lfsr_seed_rdy  (lfsr_seed_rdy),
    .misr_req_val   (misr_req_val),
    .misr_req_count (misr_req_count),
    .misr_req_rdy   (misr_req_rdy),
    .misr_resp_val  (misr_resp_val),
    .misr_resp_sig  (misr_resp_sig),
    .misr_resp_rdy  (misr_resp_rdy)
  );

  // Pattern source
  lbist_lfsr u_lfsr (
    .clk      (clk),
    .reset    (reset),
    .seed_val (lfsr_seed_val),
    .seed     (lfsr_seed),
    .seed_rdy (lfsr_seed_rdy),
    .step     (lfsr_step),
    .pattern  (pattern)
  );

  lbist_cut u_cut (
    .clk        (clk),
    .reset      (reset),
    .pattern    (pattern),
    .fault_mask (fault_mask),
    .response   (cut_response)
  );

  // Response compactor, also paces the LFSR
  lbist_misr u_misr (
    .clk       (clk),
    .reset     (reset),
    .req_val   (misr_req_val),
    .req_count (misr_req_count),
    .req_rdy   (misr_req_rdy),
    .data      (cut_response),
    .lfsr_step (lfsr_step),
    .resp_val  (misr_resp_val),
    .resp_sig  (misr_resp_sig),
    .resp_rdy  (misr_resp_rdy)
  );

endmodule

// ==== lbist_properties.sv ====
// ======================================================================
// Concurrent checks on the requestor handshakes of the LBIST top
// level, attached to every lbist_top instance by bind.
// ======================================================================

module lbist_properties import lbist_pkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    lbist_req_val,
  input logic    lbist_req_rdy,
  input logic    lbist_resp_val,
  input result_t lbist_resp_msg,
  input logic    lbist_resp_rdy
);

  logic busy_q;   // Between request and response handshakes
  logic failed;   // Set by any failing assertion

  initial failed = 1'b0;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (lbist_req_val && lbist_req_rdy) begin
      busy_q <= 1'b1;
    end else if (lbist_resp_val && lbist_resp_rdy) begin
      busy_q <= 1'b0;
    end
  end

  resp_hold: assert property (@(posedge clk) disable iff (reset)
    lbist_resp_val && !lbist_resp_rdy |=> lbist_resp_val && $stable(lbist_resp_msg))
    else begin
      failed = 1'b1;
      $error("Response dropped or changed before its handshake");
    end

  busy_not_ready: assert property (@(posedge clk) disable iff (reset)
    busy_q |-> !lbist_req_rdy)
    else begin
      failed = 1'b1;
      $error("Request ready while a run is in progress");
    end

  resp_excludes_ready: assert property (@(posedge clk) disable iff (reset)
    !(lbist_resp_val && lbist_req_rdy))
    else begin
      failed = 1'b1;
      $error("Response valid together with request ready");
    end

  resp_low_after_reset: assert property (@(posedge clk) reset |=> !lbist_resp_val)
    else begin
      failed = 1'b1;
      $error("Response valid right after reset");
    end

endmodule

bind lbist_top lbist_properties u_properties (
  .clk            (clk),
  .reset          (reset),
  .lbist_req_val  (lbist_req_val),
  .lbist_req_rdy  (lbist_req_rdy),
  .lbist_resp_val (lbist_resp_val),
  .lbist_resp_msg (lbist_resp_msg),
  .lbist_resp_rdy (lbist_resp_rdy)
);

// ==== lbist_tb.sv ====
// ======================================================================
// Testbench for the LBIST top level. Each test comes from the pattern
// file as a fault mask, a response back-pressure delay and the
// expected pass map. Runs the tests in order with random idle gaps.
// ======================================================================

module lbist_tb import lbist_pkg::*; ();

  localparam int NUM_TESTS = 10;
  localparam int TIMEOUT   = 1000;   // Cycles, a full run takes about 300

  logic    clk;
  logic    reset;
  logic    lbist_req_val;
  logic    lbist_req_rdy;
  logic    lbist_resp_val;
  result_t lbist_resp_msg;
  logic    lbist_resp_rdy;
  sig_t    fault_mask;

  logic [31:0] tests [3*NUM_TESTS];  // Mask, delay, expected map per test

  lbist_top DUT (
    .clk            (clk),
    .reset          (reset),
    .lbist_req_val  (lbist_req_val),
    .lbist_req_rdy  (lbist_req_rdy),
    .lbist_resp_val (lbist_resp_val),
    .lbist_resp_msg (lbist_resp_msg),
    .lbist_resp_rdy (lbist_resp_rdy),
    .fault_mask     (fault_mask)
  );

  always #2 clk = ~clk;

  // Bound handshake assertions raise this flag on failure
  always @(negedge clk) begin
    if (DUT.u_properties.failed) begin
      $display("TB FAILED");
      $fatal(1, "Handshake assertion failed");
    end
  end

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail: %s is %h, expected %h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Value check failed");
    end
  endtask

  task automatic timed_out(string what);
    $display("TB FAILED");
    $fatal(1, "Timed out waiting for %s", what);
  endtask

  // ====================================================================
  // One request, wait for the pass map, hold it off, then accept it
  // ====================================================================

  task automatic run_test(sig_t mask, int delay, result_t expected);
    int cycles;
    int i;
    cycles = 0;
    @(negedge clk);
    while (!lbist_req_rdy) begin
      if (cycles == TIMEOUT) timed_out("the request ready");
      cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    fault_mask    = mask;              // Controller is idle here
    lbist_req_val = 1'b1;
    @(negedge clk);
    check_value("lbist_req_rdy", 32'(lbist_req_rdy), 32'd1);
    @(posedge clk);                    // Request handshake
    #1;
    lbist_req_val = 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!lbist_resp_val) begin
      check_value("lbist_req_rdy", 32'(lbist_req_rdy), 32'd0);
      if (cycles == TIMEOUT) timed_out("the response valid");
      cycles++;
      @(negedge clk);
    end
    // Map must hold while the requestor stalls
    for (i = 0; i <= delay; i++) begin
      check_value("lbist_resp_val", 32'(lbist_resp_val), 32'd1);
      check_value("lbist_resp_msg", 32'(lbist_resp_msg), 32'(expected));
      check_value("lbist_req_rdy", 32'(lbist_req_rdy), 32'd0);
      if (i < delay) @(negedge clk);
    end
    @(posedge clk);
    #1;
    lbist_resp_rdy = 1'b1;
    @(posedge clk);                    // Response handshake
    #1;
    lbist_resp_rdy = 1'b0;
    @(negedge clk);
    check_value("lbist_resp_val", 32'(lbist_resp_val), 32'd0);
    check_value("lbist_req_rdy", 32'(lbist_req_rdy), 32'd1);
  endtask

  initial begin
    int t;
    clk            = 1'b0;
    reset          = 1'b1;
    lbist_req_val  = 1'b0;
    lbist_resp_rdy = 1'b0;
    fault_mask     = '0;
    void'($urandom(32'h2d25e3e4));
    $readmemh("lbist_patterns.txt", tests);
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("lbist_req_rdy", 32'(lbist_req_rdy), 32'd1);
    check_value("lbist_resp_val", 32'(lbist_resp_val), 32'd0);
    for (t = 0; t < NUM_TESTS; t++) begin
      repeat ($urandom % 6) @(posedge clk);   // Idle gap of 0 to 5 cycles
      run_test(tests[3*t], tests[3*t+1], result_t'(tests[3*t+2]));
    end
    if (DUT.u_properties.failed) begin
      $display("TB FAILED");
      $fatal(1, "Handshake assertion failed");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== lbist_patterns.txt ====
// Columns, hex: fault_mask  response_delay_cycles  expected_pass_map
// A zero mask expects all runs to pass; any forced output bit fails every run
00000000 0 ff
00000000 3 ff
00000001 0 00
00000000 5 ff
80000000 2 00
ffffffff 0 00
00000000 0 ff
00010000 4 00
0000ff00 1 00
00000000 2 ff

// ==== filelist.f ====
lbist_pkg.sv
lbist_lfsr.sv
lbist_cut.sv
lbist_misr.sv
lbist_controller.sv
lbist_top.sv
lbist_properties.sv
lbist_tb.sv

// ==== Makefile ====
SOURCES = lbist_pkg.sv lbist_lfsr.sv lbist_cut.sv lbist_misr.sv lbist_controller.sv \
          lbist_top.sv lbist_properties.sv lbist_tb.sv

obj_dir/Vlbist_tb: $(SOURCES) filelist.f
	verilator --binary --timing --assert --top-module lbist_tb -f filelist.f

run: obj_dir/Vlbist_tb
	./obj_dir/Vlbist_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
